//--- design/spi_mem_array.sv
/* 128 x 8 single-port memory with a registered read. Contents are undefined
   after power up and are kept through reset. */

`timescale 1ns/1ps
`default_nettype none

module spi_mem_array (
  input  wire                       cs,
  input  wire spi_mem_pkg::mem_req_t mem_req,
  output spi_mem_pkg::byte_t        rdata
);

  localparam int DEPTH = 1 << spi_mem_pkg::ADDR_W;

  spi_mem_pkg::byte_t mem [DEPTH];

  //------------------------------------------------------------
  // Write port and registered read
  //------------------------------------------------------------
  always_ff @(posedge cs) begin
    if (mem_req.wr_en) begin
      mem[mem_req.addr] <= mem_req.wdata;
    end
  end

  // Valid one cycle after rd_en
  always_ff @(posedge cs) begin
    if (mem_req.rd_en) begin
      rdata <= mem[mem_req.addr];
    end
  end

endmodule

`default_nettype wire

//--- design/spi_mem_ctrl.sv
/* Transaction controller. Command byte is {addr[6:0], wr}. The address advances
   after each data byte and wraps from 127 to 0. Reads prefetch one byte ahead. */

`timescale 1ns/1ps
`default_nettype none

module spi_mem_ctrl (
  input  wire                   cs,
  input  wire                   rst_n,
  input  wire spi_mem_pkg::rx_evt_t rx_evt,
  output spi_mem_pkg::mem_req_t mem_req,
  output logic                  tx_load,
  output logic                  read_phase
);

  spi_mem_pkg::ctrl_state_e state;
  spi_mem_pkg::addr_t       addr_q;
  spi_mem_pkg::addr_t       addr_inc;
  spi_mem_pkg::addr_t       cmd_addr;
  spi_mem_pkg::addr_t       req_addr;
  spi_mem_pkg::byte_t       req_wdata;
  logic                     cmd_is_wr;
  logic                     wr_en_q;
  logic                     rd_en_q;

  // Command byte fields
  assign cmd_addr  = rx_evt.rx_byte[7:1];
  assign cmd_is_wr = rx_evt.rx_byte[0];

  // Natural 7-bit wrap from 127 to 0
  assign addr_inc = addr_q + spi_mem_pkg::addr_t'(1);

  //------------------------------------------------------------
  // State machine and address counter
  //------------------------------------------------------------
  always_ff @(posedge cs or negedge rst_n) begin
    if (!rst_n) begin
      state   <= spi_mem_pkg::ST_CMD;
      addr_q  <= '0;
      wr_en_q <= 1'b0;
      rd_en_q <= 1'b0;
      tx_load <= 1'b0;
    end else begin
      wr_en_q <= 1'b0;
      rd_en_q <= 1'b0;
      tx_load <= rd_en_q;                       // rdata is ready now

      if (rx_evt.sel_end) begin
        state <= spi_mem_pkg::ST_CMD;
      end else if (rx_evt.byte_done) begin
        case (state)
          spi_mem_pkg::ST_CMD: begin
            addr_q <= cmd_addr;
            if (cmd_is_wr) begin
              state <= spi_mem_pkg::ST_WRITE;
            end else begin
              state   <= spi_mem_pkg::ST_READ;
              rd_en_q <= 1'b1;                  // First read byte
            end
          end

          spi_mem_pkg::ST_WRITE: begin
            wr_en_q <= 1'b1;
            addr_q  <= addr_inc;
          end

          spi_mem_pkg::ST_READ: begin
            rd_en_q <= 1'b1;                    // Fetch the next byte
            addr_q  <= addr_inc;
          end

          default: begin
            state <= spi_mem_pkg::ST_CMD;
          end
        endcase
      end
    end
  end

  //------------------------------------------------------------
  // Request payload
  //------------------------------------------------------------
  always_ff @(posedge cs) begin
    if (rx_evt.byte_done) begin
      case (state)
        spi_mem_pkg::ST_CMD: begin
          req_addr <= cmd_addr;
        end

        spi_mem_pkg::ST_WRITE: begin
          req_addr  <= addr_q;                  // Current location
          req_wdata <= rx_evt.rx_byte;
        end

        spi_mem_pkg::ST_READ: begin
          req_addr <= addr_inc;                 // One ahead of the byte on miso
        end

        default: begin
          req_addr <= addr_q;
        end
      endcase
    end
  end

  assign mem_req = '{wr_en: wr_en_q,
                     rd_en: rd_en_q,
                     addr:  req_addr,
                     wdata: req_wdata};

  assign read_phase = (state == spi_mem_pkg::ST_READ);

endmodule

`default_nettype wire

//--- design/spi_mem_pkg.sv
/* Shared types for the SPI slave memory. The address width is fixed at 7 by the
   command byte layout, so the memory is always 128 bytes deep. */

`default_nettype none

package spi_mem_pkg;

  //------------------------------------------------------------
  // Widths
  //------------------------------------------------------------
  localparam int ADDR_W = 7;                   // Address bits in the command byte

  typedef logic [ADDR_W-1:0] addr_t;           // Memory address
  typedef logic [7:0]        byte_t;           // One SPI data byte
  typedef logic [2:0]        bit_cnt_t;        // Bit position inside a byte

  //------------------------------------------------------------
  // Controller states
  //------------------------------------------------------------
  typedef enum logic [1:0] {
    ST_CMD,                                    // Waiting for the command byte
    ST_WRITE,                                  // Data bytes go into memory
    ST_READ                                    // Data bytes come out of memory
  } ctrl_state_e;

  //------------------------------------------------------------
  // Block interfaces
  //------------------------------------------------------------
  // Events from the input side, all in the cs domain
  typedef struct packed {
    logic  sel;                                // Slave selected, active high
    logic  sck_fall;                           // Falling sclk edge seen
    logic  sel_end;                            // ss_n went high
    logic  byte_done;                          // Eighth bit sampled
    byte_t rx_byte;                            // Assembled byte
  } rx_evt_t;

  // Request to the memory array
  typedef struct packed {
    logic  wr_en;                              // Write strobe
    logic  rd_en;                              // Read strobe
    addr_t addr;                               // Target location
    byte_t wdata;                              // Write data
  } mem_req_t;

endpackage

`default_nettype wire

//--- design/spi_mem_top.sv
/* SPI mode 0 slave memory, 128 bytes, clocked by cs. The sclk half period must
   be at least 6 cs cycles. MISO needs an external buffer enabled by miso_oe. */

`timescale 1ns/1ps
`default_nettype none

module spi_mem_top #(
  parameter int unsigned SYNC_STAGES = 2        // Synchronizer depth per pin
) (
  input  wire cs,
  input  wire rst_n,
  input  wire sclk,
  input  wire ss_n,
  input  wire mosi,
  output wire miso,
  output wire miso_oe
);

  wire spi_mem_pkg::rx_evt_t  rx_evt;
  wire spi_mem_pkg::mem_req_t mem_req;
  wire spi_mem_pkg::byte_t    rdata;
  wire                        tx_load;
  wire                        read_phase;

  //------------------------------------------------------------
  // Input side
  //------------------------------------------------------------
  spi_rx_front #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_rx_front (
    .cs     (cs),
    .rst_n  (rst_n),
    .sclk   (sclk),
    .ss_n   (ss_n),
    .mosi   (mosi),
    .rx_evt (rx_evt)
  );

  //------------------------------------------------------------
  // Processing part
  //------------------------------------------------------------
  spi_mem_ctrl u_ctrl (
    .cs         (cs),
    .rst_n      (rst_n),
    .rx_evt     (rx_evt),
    .mem_req    (mem_req),
    .tx_load    (tx_load),
    .read_phase (read_phase)
  );

  spi_mem_array u_array (
    .cs      (cs),
    .mem_req (mem_req),
    .rdata   (rdata)
  );

  //------------------------------------------------------------
  // Output side
  //------------------------------------------------------------
  spi_tx_shifter u_tx_shifter (
    .cs         (cs),
    .rst_n      (rst_n),
    .sck_fall   (rx_evt.sck_fall),
    .sel        (rx_evt.sel),
    .sel_end    (rx_evt.sel_end),
    .tx_load    (tx_load),
    .read_phase (read_phase),
    .rdata      (rdata),
    .miso       (miso),
    .miso_oe    (miso_oe)
  );

endmodule

`default_nettype wire

//--- design/spi_rx_front.sv
/* SPI mode 0 input side. Pins are sampled on cs, so each sclk half period must
   last at least 6 cs cycles. SYNC_STAGES must be 2 or more. */

`timescale 1ns/1ps
`default_nettype none

module spi_rx_front #(
  parameter int unsigned SYNC_STAGES = 2
) (
  input  wire                  cs,
  input  wire                  rst_n,
  input  wire                  sclk,
  input  wire                  ss_n,
  input  wire                  mosi,
  output spi_mem_pkg::rx_evt_t rx_evt
);

  // Idle pin pattern {sclk, ss_n, mosi}, deselected
  localparam logic [2:0] PIN_IDLE = 3'b010;

  logic [SYNC_STAGES-1:0][2:0] pin_sync;
  logic                        sclk_s;
  logic                        ss_s;
  logic                        mosi_s;
  logic                        sel;
  logic                        sclk_q;
  logic                        ss_q;
  logic                        sck_rise;
  logic                        sck_fall_q;
  logic                        sel_end_q;
  logic                        byte_done_q;
  spi_mem_pkg::bit_cnt_t       bit_cnt;
  spi_mem_pkg::byte_t          rx_sh;

  //------------------------------------------------------------
  // Pin synchronizers
  //------------------------------------------------------------
  always_ff @(posedge cs or negedge rst_n) begin
    if (!rst_n) begin
      pin_sync <= {SYNC_STAGES{PIN_IDLE}};
    end else begin
      pin_sync <= {pin_sync[SYNC_STAGES-2:0], {sclk, ss_n, mosi}};
    end
  end

  assign {sclk_s, ss_s, mosi_s} = pin_sync[SYNC_STAGES-1];
  assign sel      = ~ss_s;
  assign sck_rise = sel & sclk_s & ~sclk_q;      // Sample point in mode 0

  //------------------------------------------------------------
  // Edge strobes
  //------------------------------------------------------------
  always_ff @(posedge cs or negedge rst_n) begin
    if (!rst_n) begin
      sclk_q     <= 1'b0;
      ss_q       <= 1'b1;
      sck_fall_q <= 1'b0;
      sel_end_q  <= 1'b0;
    end else begin
      sclk_q     <= sclk_s;
      ss_q       <= ss_s;
      sck_fall_q <= sel & sclk_q & ~sclk_s;
      sel_end_q  <= ss_s & ~ss_q;               // Rising ss_n
    end
  end

  //------------------------------------------------------------
  // Receive shift register and bit counter
  //------------------------------------------------------------
  always_ff @(posedge cs or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt     <= '0;
      byte_done_q <= 1'b0;
    end else begin
      byte_done_q <= 1'b0;
      if (!sel) begin
        bit_cnt <= '0;                          // Drop partial byte
      end else if (sck_rise) begin
        bit_cnt     <= bit_cnt + 1'b1;
        byte_done_q <= (bit_cnt == 3'd7);
      end
    end
  end

  always_ff @(posedge cs) begin
    if (sck_rise) begin
      rx_sh <= {rx_sh[6:0], mosi_s};            // MSB first
    end
  end

  assign rx_evt = '{sel:       sel,
                    sck_fall:  sck_fall_q,
                    sel_end:   sel_end_q,
                    byte_done: byte_done_q,
                    rx_byte:   rx_sh};

endmodule

`default_nettype wire

//--- design/spi_tx_shifter.sv
/* MISO shifter for mode 0. A loaded byte waits for the next falling sclk edge.
   miso_oe drives an external buffer, this block has no tristate. */

`timescale 1ns/1ps
`default_nettype none

module spi_tx_shifter (
  input  wire                cs,
  input  wire                rst_n,
  input  wire                sck_fall,
  input  wire                sel,
  input  wire                sel_end,
  input  wire                tx_load,
  input  wire                read_phase,
  input  wire spi_mem_pkg::byte_t rdata,
  output logic               miso,
  output logic               miso_oe
);

  spi_mem_pkg::byte_t hold_q;
  spi_mem_pkg::byte_t sh_q;
  logic               pending;
  logic               oe_q;

  // Holding register for the prefetched byte
  always_ff @(posedge cs) begin
    if (tx_load) begin
      hold_q <= rdata;
    end
  end

  //------------------------------------------------------------
  // Shift register and output enable
  //------------------------------------------------------------
  always_ff @(posedge cs or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
      sh_q    <= '0;
      oe_q    <= 1'b0;
    end else begin
      oe_q <= read_phase & sel & ~sel_end;
      if (sel_end) begin
        pending <= 1'b0;
        sh_q    <= '0;
      end else begin
        if (sck_fall) begin
          sh_q <= pending ? hold_q : {sh_q[6:0], 1'b0};
        end
        if (tx_load) begin
          pending <= 1'b1;
        end else if (sck_fall) begin
          pending <= 1'b0;                      // Byte moved to shifter
        end
      end
    end
  end

  assign miso    = sh_q[7];
  assign miso_oe = oe_q;

endmodule

`default_nettype wire

//--- dv/spi_mem_tb.sv
/* Testbench for the SPI slave memory. The master runs mode 0 with an sclk half
   period of 8 cs cycles. Only locations written earlier are read back. */

`timescale 1ns/1ps
`default_nettype none

module spi_mem_tb;

  localparam int HALF     = 8;                  // sclk half period in cs cycles
  localparam int GAP      = 16;                 // Idle cycles between transactions
  localparam int OE_LIMIT = 10;                 // Max cycles for miso_oe to drop

  logic        cs;
  logic        rst_n;
  logic        sclk;
  logic        ss_n;
  logic        mosi;
  wire         miso;
  wire         miso_oe;

  logic [7:0]  model [128];                     // Mirror of every write
  logic [31:0] rng_state;
  int          checks;
  int          errors;
  int          timeouts;

  spi_mem_top #(
    .SYNC_STAGES (2)
  ) i_dut (
    .cs      (cs),
    .rst_n   (rst_n),
    .sclk    (sclk),
    .ss_n    (ss_n),
    .mosi    (mosi),
    .miso    (miso),
    .miso_oe (miso_oe)
  );

  initial begin
    cs = 1'b0;
    forever #4 cs = ~cs;
  end

  //------------------------------------------------------------
  // Random data and checks
  //------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_rand_byte(output logic [7:0] b);
    rng_state = lcg_next(rng_state);
    b = rng_state[23:16];                       // Upper bits mix better
  endtask

  task automatic check_oe(input logic exp, input string name);
    checks++;
    assert (miso_oe === exp) else begin
      $display("ERR %s miso_oe expected %0b actual %0b", name, exp, miso_oe);
      errors++;
    end
  endtask

  //------------------------------------------------------------
  // SPI master, mode 0
  //------------------------------------------------------------
  task automatic shift_bits(input logic [7:0] tx, input int nbits, input logic oe_exp,
                            input string name, output logic [7:0] rx);
    logic [7:0] tx_sh;
    int         i;
    tx_sh = tx;
    rx    = 8'h00;
    for (i = 0; i < nbits; i++) begin
      mosi  = tx_sh[7];                         // MSB first
      tx_sh = {tx_sh[6:0], 1'b0};
      repeat (HALF) @(negedge cs);
      check_oe(oe_exp, name);
      rx   = {rx[6:0], miso};                   // Sample at the rising edge
      sclk = 1'b1;
      repeat (HALF) @(negedge cs);
      sclk = 1'b0;
    end
  endtask

  task automatic wait_oe_low(input string name);
    int n;
    n = 0;
    while (miso_oe !== 1'b0 && n < OE_LIMIT) begin
      @(negedge cs);
      n++;
    end
    if (miso_oe !== 1'b0) begin
      $display("Timeout in %s: miso_oe still high %0d cycles after ss_n rose",
               name, OE_LIMIT);
      timeouts++;
    end
  endtask

  task automatic end_xfer(input string name);
    repeat (HALF) @(negedge cs);
    ss_n = 1'b1;
    mosi = 1'b0;
    wait_oe_low(name);
    repeat (GAP) @(negedge cs);
  endtask

  task automatic write_burst(input logic [6:0] start, input int count, input string name);
    logic [6:0] a;
    logic [7:0] d;
    logic [7:0] rx;
    int         k;
    a    = start;
    ss_n = 1'b0;
    shift_bits({start, 1'b1}, 8, 1'b0, name, rx);
    for (k = 0; k < count; k++) begin
      next_rand_byte(d);
      model[a] = d;
      shift_bits(d, 8, 1'b0, name, rx);
      a = a + 7'd1;                             // Wraps 127 to 0
    end
    end_xfer(name);
  endtask

  task automatic read_burst(input logic [6:0] start, input int count, input string name);
    logic [6:0] a;
    logic [7:0] rx;
    int         k;
    a    = start;
    ss_n = 1'b0;
    shift_bits({start, 1'b0}, 8, 1'b0, name, rx);
    for (k = 0; k < count; k++) begin
      shift_bits(8'h00, 8, 1'b1, name, rx);
      checks++;
      assert (rx === model[a]) else begin
        $display("ERR %s addr %0d expected %02h actual %02h", name, a, model[a], rx);
        errors++;
      end
      a = a + 7'd1;
    end
    end_xfer(name);
  endtask

  // Write command, then only part of a data byte
  task automatic abort_write(input logic [6:0] start, input int nbits, input string name);
    logic [7:0] d;
    logic [7:0] rx;
    ss_n = 1'b0;
    shift_bits({start, 1'b1}, 8, 1'b0, name, rx);
    next_rand_byte(d);
    shift_bits(d, nbits, 1'b0, name, rx);
    end_xfer(name);
  endtask

  //------------------------------------------------------------
  // Test sequence
  //------------------------------------------------------------
  initial begin
    rst_n     = 1'b0;
    sclk      = 1'b0;
    ss_n      = 1'b1;
    mosi      = 1'b0;
    rng_state = 32'h35da;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;

    repeat (8) @(negedge cs);
    rst_n = 1'b1;
    repeat (4) @(negedge cs);
    check_oe(1'b0, "reset");

    write_burst(7'd21, 1, "single");
    read_burst(7'd21, 1, "single");

    write_burst(7'd40, 16, "burst");
    read_burst(7'd40, 16, "burst");

    write_burst(7'd126, 4, "wrap");             // 126, 127, 0, 1
    read_burst(7'd126, 4, "wrap");

    write_burst(7'd90, 1, "abort_setup");
    abort_write(7'd90, 5, "abort");
    read_burst(7'd90, 1, "abort");              // Old value kept
    write_burst(7'd90, 2, "after_abort");
    read_burst(7'd90, 2, "after_abort");

    write_burst(7'd0, 128, "sweep");
    read_burst(7'd0, 128, "sweep");

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SPI memory testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=spi_mem_sim
LOG=sim.log

verilator --binary --assert -f verilog.f --top-module spi_mem_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" 2>&1 | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "Simulation exited with an error"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi

if ! grep -q "Done: no errors" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi

exit 0

//--- verilog.f
design/spi_mem_pkg.sv
design/spi_rx_front.sv
design/spi_mem_ctrl.sv
design/spi_mem_array.sv
design/spi_tx_shifter.sv
design/spi_mem_top.sv
dv/spi_mem_tb.sv
